/* common/la_defines.svh */
`ifndef LA_DEFINES_SVH
`define LA_DEFINES_SVH

// Probe word width
`define LA_SAMPLE_W 32

// Ring buffer address width, 1024 words deep
`define LA_MEM_AW 10

// Read count and delay count fields
`define LA_COUNT_W 16

// Host command word layout
`define LA_OPCODE_W 8
`define LA_CMD_DATA_W 32

`endif

/* common/la_pkg.sv */
`include "la_defines.svh"

package la_pkg;

  // One probe word as stored and sent back
  typedef logic [`LA_SAMPLE_W-1:0] la_sample_t;

  // Command word from the host link, data in the upper bits
  typedef struct packed {
    logic [`LA_CMD_DATA_W-1:0] config_data;
    logic [`LA_OPCODE_W-1:0]   opcode;
  } la_cmd_t;

  typedef enum logic [`LA_OPCODE_W-1:0] {
    OP_RESET      = 8'h00,  // Abort to idle
    OP_ARM        = 8'h01,  // Start a capture
    OP_SET_COUNTS = 8'h81,  // Delay in 31:16, read in 15:0
    OP_TRIG_MASK  = 8'hC0,
    OP_TRIG_VALUE = 8'hC1
  } la_opcode_e;

  // Trigger settings
  typedef struct packed {
    logic [`LA_SAMPLE_W-1:0] mask;
    logic [`LA_SAMPLE_W-1:0] value;
    logic                    ext_en;  // From bit 0 of the mask command
  } la_trig_cfg_t;

  // Field order follows config_data of OP_SET_COUNTS
  typedef struct packed {
    logic [`LA_COUNT_W-1:0] delay_count;  // Words kept after the trigger word
    logic [`LA_COUNT_W-1:0] read_count;   // Words sent back
  } la_count_t;

endpackage

/* logic/la_cfg_regs.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module la_cfg_regs (
  input  logic                 sys_clk,
  input  logic                 sys_rst,
  input  la_pkg::la_cmd_t      cmd,
  input  logic                 execute,
  output la_pkg::la_trig_cfg_t trig_cfg,
  output la_pkg::la_count_t    counts,
  output logic                 arm_pulse,
  output logic                 abort_pulse
);

  la_pkg::la_opcode_e opcode;

  // Unlisted opcodes simply fall to the default branch
  assign opcode = la_pkg::la_opcode_e'(cmd.opcode);

  // Settings registers
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      trig_cfg <= '0;
      counts   <= '0;
    end else if (execute) begin
      case (opcode)
        la_pkg::OP_SET_COUNTS: begin
          counts <= cmd.config_data;  // Same bit layout as the struct
        end
        la_pkg::OP_TRIG_MASK: begin
          trig_cfg.mask   <= cmd.config_data;
          trig_cfg.ext_en <= cmd.config_data[0];
        end
        la_pkg::OP_TRIG_VALUE: begin
          trig_cfg.value <= cmd.config_data;
        end
        default: begin
          // Arm, reset and unknown codes leave settings alone
        end
      endcase
    end
  end

  // Control strobes one cycle after execute
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      arm_pulse   <= 1'b0;
      abort_pulse <= 1'b0;
    end else begin
      arm_pulse   <= execute && (opcode == la_pkg::OP_ARM);
      abort_pulse <= execute && (opcode == la_pkg::OP_RESET);
    end
  end

endmodule

/* trigger/la_trigger.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module la_trigger (
  input  logic                   sys_clk,
  input  logic                   sys_rst,
  input  la_pkg::la_trig_cfg_t   trig_cfg,
  input  logic                   wr_en,
  input  la_pkg::la_sample_t     wr_data,
  input  logic [`LA_MEM_AW-1:0]  wr_addr,
  input  logic                   ext_trigger,
  output logic                   trig_hit,
  output logic [`LA_MEM_AW-1:0]  trig_addr
);

  logic value_match;
  logic ext_match;
  logic hit_now;

  // Only bits set in the mask take part
  assign value_match = ((wr_data ^ trig_cfg.value) & trig_cfg.mask) == '0;

  // External input counts only alongside a taken word
  assign ext_match = trig_cfg.ext_en && ext_trigger;

  assign hit_now = wr_en && (value_match || ext_match);

  // Hit flag, one cycle behind the written word
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      trig_hit <= 1'b0;
    end else begin
      trig_hit <= hit_now;
    end
  end

  // Address of the matching word, held between hits
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      trig_addr <= '0;
    end else if (hit_now) begin
      trig_addr <= wr_addr;
    end
  end

  // Capture logic relies on trig_addr only moving with a hit
  ap_addr_hold: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    !trig_hit |-> $stable(trig_addr)
  );

endmodule

/* capture/la_capture_ctrl.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module la_capture_ctrl (
  input  logic                   sys_clk,
  input  logic                   sys_rst,
  input  logic                   arm_pulse,
  input  logic                   abort_pulse,
  input  la_pkg::la_count_t      counts,
  input  la_pkg::la_sample_t     sample_data,
  input  logic                   sample_valid,
  input  logic                   trig_hit,
  input  logic [`LA_MEM_AW-1:0]  trig_addr,
  input  logic                   rd_done,
  output logic                   wr_en,
  output logic [`LA_MEM_AW-1:0]  wr_addr,
  output la_pkg::la_sample_t     wr_data,
  output logic                   rd_start,
  output logic [`LA_MEM_AW-1:0]  last_addr,
  output logic                   arm_led,
  output logic                   trigger_led,
  output logic                   ext_trigger_out
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_POST,
    ST_READOUT
  } state_e;

  state_e                 state;
  logic [`LA_MEM_AW-1:0]  wr_ptr;
  logic [`LA_COUNT_W-1:0] remain;     // Post-trigger words still to take
  logic                   trig_led_q;
  logic                   accept;

  // First hit while armed
  assign accept = (state == ST_ARMED) && trig_hit;

  // Take words while armed or still short of the delay
  always_comb begin
    case (state)
      ST_ARMED: wr_en = sample_valid && !(accept && (counts.delay_count == '0));
      ST_POST:  wr_en = sample_valid && (remain != '0);
      default:  wr_en = 1'b0;
    endcase
  end

  assign wr_addr         = wr_ptr;
  assign wr_data         = sample_data;  // Written straight through
  assign arm_led         = (state == ST_ARMED);
  assign trigger_led     = trig_led_q;
  assign ext_trigger_out = accept;

  // Ring write pointer, wraps with the address width
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      state      <= ST_IDLE;
      remain     <= '0;
      last_addr  <= '0;
      trig_led_q <= 1'b0;
      rd_start   <= 1'b0;
    end else begin
      rd_start <= 1'b0;
      if (abort_pulse) begin
        state      <= ST_IDLE;
        trig_led_q <= 1'b0;
      end else begin
        case (state)
          ST_IDLE: begin
            if (arm_pulse) begin
              state      <= ST_ARMED;
              trig_led_q <= 1'b0;
            end
          end
          ST_ARMED: begin
            if (accept) begin
              state      <= ST_POST;
              trig_led_q <= 1'b1;
              // Final word sits delay_count past the trigger word
              last_addr  <= trig_addr + counts.delay_count[`LA_MEM_AW-1:0];
              // Word taken during the hit latency already counts
              remain     <= counts.delay_count - {{(`LA_COUNT_W-1){1'b0}}, wr_en};
            end
          end
          ST_POST: begin
            if (remain == '0) begin
              state    <= ST_READOUT;
              rd_start <= 1'b1;
            end else if (wr_en) begin
              remain <= remain - 1'b1;
            end
          end
          default: begin
            if (rd_done) state <= ST_IDLE;  // Back to rest until next arm
          end
        endcase
      end
    end
  end

  // Buffer is frozen while it is read out
  ap_no_wr_readout: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    (state == ST_READOUT) |-> !wr_en
  );

  // Later hits in the same capture are ignored
  ap_ext_single: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    ext_trigger_out |=> !ext_trigger_out
  );

endmodule

/* capture/la_sample_ram.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module la_sample_ram (
  input  logic                   sys_clk,
  input  logic                   wr_en,
  input  logic [`LA_MEM_AW-1:0]  wr_addr,
  input  la_pkg::la_sample_t     wr_data,
  input  logic [`LA_MEM_AW-1:0]  rd_addr,
  output la_pkg::la_sample_t     rd_data
);

  localparam int DEPTH = 1 << `LA_MEM_AW;

  la_pkg::la_sample_t mem [DEPTH];  // Block RAM

  // Write port
  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge sys_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* logic/la_readout.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module la_readout (
  input  logic                   sys_clk,
  input  logic                   sys_rst,
  input  logic                   rd_start,
  input  logic [`LA_MEM_AW-1:0]  last_addr,
  input  la_pkg::la_count_t      counts,
  input  logic                   abort_pulse,
  input  la_pkg::la_sample_t     rd_data,
  input  logic                   busy,
  output logic [`LA_MEM_AW-1:0]  rd_addr,
  output logic                   send,
  output la_pkg::la_sample_t     send_data,
  output logic                   rd_done
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,  // RAM latency
    RD_SEND   // Data valid, waiting for busy low
  } rd_state_e;

  rd_state_e              state;
  logic [`LA_MEM_AW-1:0]  rd_ptr;
  logic [`LA_COUNT_W-1:0] left;    // Words still to send

  assign rd_addr   = rd_ptr;
  assign send_data = rd_data;
  assign send      = (state == RD_SEND) && !busy && !abort_pulse;

  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      state   <= RD_IDLE;
      rd_ptr  <= '0;
      left    <= '0;
      rd_done <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      if (abort_pulse) begin
        state <= RD_IDLE;  // Drop the rest, no done
      end else begin
        case (state)
          RD_IDLE: begin
            if (rd_start) begin
              rd_ptr <= last_addr;  // Newest word first
              left   <= counts.read_count;
              if (counts.read_count == '0) rd_done <= 1'b1;
              else                         state   <= RD_WAIT;
            end
          end
          RD_WAIT: state <= RD_SEND;
          default: begin
            if (send) begin
              rd_ptr <= rd_ptr - 1'b1;  // Wraps below zero
              left   <= left - 1'b1;
              if (left == 'd1) begin
                state   <= RD_IDLE;
                rd_done <= 1'b1;
              end else begin
                state <= RD_WAIT;
              end
            end
          end
        endcase
      end
    end
  end

  // Host link cannot take a word while busy
  ap_send_busy: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    send |-> !busy
  );

endmodule

/* logic/la_top.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module la_top (
  input  logic               sys_clk,
  input  logic               sys_rst,
  input  la_pkg::la_cmd_t    cmd,
  input  logic               execute,
  input  la_pkg::la_sample_t sample_data,
  input  logic               sample_valid,
  input  logic               ext_trigger,
  input  logic               busy,
  output logic               send,
  output la_pkg::la_sample_t send_data,
  output logic               arm_led,
  output logic               trigger_led,
  output logic               ext_trigger_out
);

  la_pkg::la_trig_cfg_t  trig_cfg;
  la_pkg::la_count_t     counts;
  logic                  arm_pulse;
  logic                  abort_pulse;
  // Buffer write side
  logic                  wr_en;
  logic [`LA_MEM_AW-1:0] wr_addr;
  la_pkg::la_sample_t    wr_data;
  // Trigger result
  logic                  trig_hit;
  logic [`LA_MEM_AW-1:0] trig_addr;
  // Readout hand-off and read side
  logic                  rd_start;
  logic                  rd_done;
  logic [`LA_MEM_AW-1:0] last_addr;
  logic [`LA_MEM_AW-1:0] rd_addr;
  la_pkg::la_sample_t    rd_data;

  la_cfg_regs cfg_regs_i (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .cmd         (cmd),
    .execute     (execute),
    .trig_cfg    (trig_cfg),
    .counts      (counts),
    .arm_pulse   (arm_pulse),
    .abort_pulse (abort_pulse)
  );

  la_trigger trigger_i (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .trig_cfg    (trig_cfg),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .wr_addr     (wr_addr),
    .ext_trigger (ext_trigger),
    .trig_hit    (trig_hit),
    .trig_addr   (trig_addr)
  );

  la_capture_ctrl capture_ctrl_i (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .arm_pulse       (arm_pulse),
    .abort_pulse     (abort_pulse),
    .counts          (counts),
    .sample_data     (sample_data),
    .sample_valid    (sample_valid),
    .trig_hit        (trig_hit),
    .trig_addr       (trig_addr),
    .rd_done         (rd_done),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_start        (rd_start),
    .last_addr       (last_addr),
    .arm_led         (arm_led),
    .trigger_led     (trigger_led),
    .ext_trigger_out (ext_trigger_out)
  );

  la_sample_ram sample_ram_i (
    .sys_clk (sys_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  la_readout readout_i (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .rd_start    (rd_start),
    .last_addr   (last_addr),
    .counts      (counts),
    .abort_pulse (abort_pulse),
    .rd_data     (rd_data),
    .busy        (busy),
    .rd_addr     (rd_addr),
    .send        (send),
    .send_data   (send_data),
    .rd_done     (rd_done)
  );

endmodule

/* sim/la_tb.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module la_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int NUM_CAPTURES = 11;
  localparam int PH_IDLE      = 0;
  localparam int PH_ARMED     = 1;
  localparam int PH_POST      = 2;
  localparam int PH_READ      = 3;  // Readout and rest until the next arm

  logic               sys_clk = 1'b0;
  logic               sys_rst;
  la_pkg::la_cmd_t    cmd;
  logic               execute;
  la_pkg::la_sample_t sample_data;
  logic               sample_valid;
  logic               ext_trigger;
  logic               busy;
  logic               send;
  la_pkg::la_sample_t send_data;
  logic               arm_led;
  logic               trigger_led;
  logic               ext_trigger_out;

  integer seed       = 32'h22dd;
  int     busy_hold  = 0;     // Busy cycles left after a send
  logic   heavy_busy = 1'b0;
  logic   send_seen  = 1'b0;

  // Reference model
  int                 ph          = PH_IDLE;
  logic               arm_d       = 1'b0;  // Arm command seen on the last edge
  logic               abort_d     = 1'b0;
  logic               hit_pending = 1'b0;  // Trigger word taken on the last edge
  logic               led_trig    = 1'b0;
  int                 post_cnt    = 0;
  la_pkg::la_sample_t m_mask      = '0;
  la_pkg::la_sample_t m_value     = '0;
  logic               m_ext_en    = 1'b0;
  int                 m_read      = 0;
  int                 m_delay     = 0;
  la_pkg::la_sample_t taken_q[$];          // Every word taken since arming
  la_pkg::la_sample_t exp_q[$];            // Sends still due, newest first

  la_top la_top_i (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .cmd             (cmd),
    .execute         (execute),
    .sample_data     (sample_data),
    .sample_valid    (sample_valid),
    .ext_trigger     (ext_trigger),
    .busy            (busy),
    .send            (send),
    .send_data       (send_data),
    .arm_led         (arm_led),
    .trigger_led     (trigger_led),
    .ext_trigger_out (ext_trigger_out)
  );

  always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input la_pkg::la_sample_t exp,
                            input la_pkg::la_sample_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Masked compare, or external input with a taken word
  function automatic logic is_trigger(input la_pkg::la_sample_t w, input logic ext);
    return ((w & m_mask) == (m_value & m_mask)) || (m_ext_en && ext);
  endfunction

  // Newest read count words, newest first
  task automatic build_expected;
    int n;
    int i;
    n = taken_q.size();
    exp_q.delete();
    for (i = 0; i < m_read; i++) begin
      exp_q.push_back(taken_q[n - 1 - i]);
    end
    ph = PH_READ;
  endtask

  task automatic update_model;
    if (hit_pending) begin
      led_trig    = 1'b1;  // Rises as arm_led falls
      hit_pending = 1'b0;
    end
    if (abort_d) begin
      ph       = PH_IDLE;
      led_trig = 1'b0;
      exp_q.delete();
    end else if (arm_d) begin
      ph       = PH_ARMED;
      led_trig = 1'b0;
      taken_q.delete();
    end else if (sample_valid && ph == PH_ARMED) begin
      taken_q.push_back(sample_data);
      if (is_trigger(sample_data, ext_trigger)) begin
        hit_pending = 1'b1;
        post_cnt    = 0;
        ph          = PH_POST;
        if (m_delay == 0) build_expected();
      end
    end else if (sample_valid && ph == PH_POST) begin
      taken_q.push_back(sample_data);  // Latency cycle word counts too
      post_cnt++;
      if (post_cnt == m_delay) build_expected();
    end
    // Strobes act one edge later
    arm_d   = execute && (cmd.opcode == la_pkg::OP_ARM);
    abort_d = execute && (cmd.opcode == la_pkg::OP_RESET);
    if (execute && cmd.opcode == la_pkg::OP_SET_COUNTS) begin
      m_read  = int'(cmd.config_data[`LA_COUNT_W-1:0]);
      m_delay = int'(cmd.config_data[2*`LA_COUNT_W-1:`LA_COUNT_W]);
    end
    if (execute && cmd.opcode == la_pkg::OP_TRIG_MASK) begin
      m_mask   = cmd.config_data;
      m_ext_en = cmd.config_data[0];
    end
    if (execute && cmd.opcode == la_pkg::OP_TRIG_VALUE) m_value = cmd.config_data;
  endtask

  // Checks use values from before this edge
  always @(posedge sys_clk) begin
    if (!sys_rst) begin
      check_flag("arm_led", (ph == PH_ARMED) || hit_pending, arm_led);
      check_flag("trigger_led", led_trig, trigger_led);
      check_flag("ext_trigger_out", hit_pending, ext_trigger_out);
      if (send) begin
        if (exp_q.size() == 0) begin
          fail_run($sformatf("send at %0t with no word left to send", $time));
        end else begin
          check_flag("busy", 1'b0, busy);
          check_word("send_data", exp_q.pop_front(), send_data);
          send_seen = 1'b1;
        end
      end
      update_model();
    end
  end

  task automatic next_cycle;
    @(negedge sys_clk);
    if (send_seen) begin
      busy_hold = rand_range(0, 5);
      send_seen = 1'b0;
    end
    if (busy_hold > 0) begin
      busy = 1'b1;
      busy_hold--;
    end else begin
      busy = heavy_busy && (($random(seed) & 3) != 0);
    end
    execute      = 1'b0;
    ext_trigger  = 1'b0;
    sample_valid = ($random(seed) & 3) != 0;
    sample_data  = $random(seed) & 32'h7fff_ffff;  // Bit 31 low, never a match
  endtask

  task automatic send_cmd(input la_pkg::la_opcode_e op, input logic [31:0] data);
    next_cycle();
    cmd.opcode      = op;
    cmd.config_data = data;
    execute         = 1'b1;
    next_cycle();
  endtask

  task automatic run_capture(input int rd_cnt, input int dly, input logic use_ext,
                             input int abort_after);
    la_pkg::la_sample_t mask;
    la_pkg::la_sample_t value;
    int                 extra;
    if (use_ext) begin
      mask  = 32'h8000_0001;  // Bit 0 is ext_en, bit 31 blocks value hits
      value = 32'h8000_0000;
    end else begin
      mask  = $random(seed) | 32'h8000_0000;
      value = $random(seed) | 32'h8000_0000;
    end
    extra = rand_range(0, 15);
    send_cmd(la_pkg::OP_TRIG_MASK, mask);
    send_cmd(la_pkg::OP_TRIG_VALUE, value);
    send_cmd(la_pkg::OP_SET_COUNTS, {16'(dly), 16'(rd_cnt)});
    send_cmd(la_pkg::OP_ARM, 32'h0);
    check_flag("arm_led", 1'b0, arm_led);  // One cycle after execute
    next_cycle();
    check_flag("arm_led", 1'b1, arm_led);  // Two cycles after execute
    while (taken_q.size() < rd_cnt + extra) begin
      next_cycle();
    end
    next_cycle();
    sample_valid = 1'b1;
    if (use_ext) begin
      ext_trigger = 1'b1;
    end else begin
      sample_data = (value & mask) | (sample_data & ~mask);
    end
    if (abort_after > 0) begin
      repeat (abort_after) next_cycle();
      send_cmd(la_pkg::OP_RESET, 32'h0);
      repeat (200) next_cycle();  // Any send here is flagged by the monitor
      check_flag("arm_led", 1'b0, arm_led);
      check_flag("trigger_led", 1'b0, trigger_led);
    end else begin
      while (!(ph == PH_READ && exp_q.size() == 0)) begin
        next_cycle();
      end
      check_flag("trigger_led", 1'b1, trigger_led);  // Held through readout
      repeat (20) next_cycle();
    end
  endtask

  initial begin
    #(CLK_PERIOD * 4000 * NUM_CAPTURES);
    fail_run("watchdog expired, the readout never finished");
  end

  initial begin
    sys_rst      = 1'b1;
    cmd          = '0;
    execute      = 1'b0;
    sample_data  = '0;
    sample_valid = 1'b0;
    ext_trigger  = 1'b0;
    busy         = 1'b0;
    repeat (5) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst = 1'b0;
    // Idle after reset, probe running
    repeat (50) next_cycle();
    check_flag("send", 1'b0, send);
    // Mask and value trigger
    repeat (3) run_capture(rand_range(1, 48), rand_range(0, 40), 1'b0, 0);
    // LED timing with no post-trigger words
    run_capture(rand_range(1, 48), 0, 1'b0, 0);
    // External trigger
    repeat (2) run_capture(rand_range(1, 48), rand_range(0, 40), 1'b1, 0);
    // Heavy host back-pressure
    heavy_busy = 1'b1;
    repeat (3) run_capture(rand_range(1, 48), rand_range(0, 40), 1'b0, 0);
    heavy_busy = 1'b0;
    // Abort in post-trigger, then a clean capture
    run_capture(16, 300, 1'b0, 20);
    run_capture(rand_range(1, 48), rand_range(0, 40), 1'b0, 0);
    $display("Regression passed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+common
common/la_pkg.sv
logic/la_cfg_regs.sv
trigger/la_trigger.sv
capture/la_capture_ctrl.sv
capture/la_sample_ram.sv
logic/la_readout.sv
logic/la_top.sv
sim/la_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the logic analyzer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module la_tb -o la_sim

out=$(./obj_dir/la_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
else
  exit 1
fi
